// ==== hw/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

   // register number and data word
   typedef logic [4:0]  reg_idx_t;
   typedef logic [31:0] word_t;

   // primary opcodes handled by the core
   typedef enum logic [5:0] {
      OP_SPECIAL = 6'h00,
      OP_ADDIU   = 6'h09,
      OP_SLTI    = 6'h0a,
      OP_SLTIU   = 6'h0b,
      OP_ANDI    = 6'h0c,
      OP_ORI     = 6'h0d,
      OP_XORI    = 6'h0e,
      OP_LUI     = 6'h0f,
      OP_LB      = 6'h20,
      OP_LH      = 6'h21,
      OP_LW      = 6'h23,
      OP_LBU     = 6'h24,
      OP_LHU     = 6'h25,
      OP_SB      = 6'h28,
      OP_SH      = 6'h29,
      OP_SW      = 6'h2b
   } opcode_e;

   // function field of special (r-type) instructions
   typedef enum logic [5:0] {
      FN_SLL  = 6'h00,
      FN_SRL  = 6'h02,
      FN_SRA  = 6'h03,
      FN_SLLV = 6'h04,
      FN_SRLV = 6'h06,
      FN_SRAV = 6'h07,
      FN_ADDU = 6'h21,
      FN_SUBU = 6'h23,
      FN_AND  = 6'h24,
      FN_OR   = 6'h25,
      FN_XOR  = 6'h26,
      FN_NOR  = 6'h27,
      FN_SLT  = 6'h2a,
      FN_SLTU = 6'h2b
   } funct_e;

   // r-type field layout
   typedef struct packed {
      opcode_e  op;
      reg_idx_t rs;
      reg_idx_t rt;
      reg_idx_t rd;
      logic [4:0] shamt;
      funct_e   funct;
   } instr_t;

   // i-type layout, low half is the immediate
   typedef struct packed {
      opcode_e  op;
      reg_idx_t rs;
      reg_idx_t rt;
      logic [15:0] imm;
   } instr_imm_t;

   typedef union packed {
      instr_t     r;
      instr_imm_t i;
   } instr_u;

endpackage

`default_nettype wire

// ==== hw/core_pkg.sv ====
`default_nettype none

package core_pkg;

   // reset pc, start of the text segment
   localparam logic [31:0] TEXT_START = 32'h0040_0000;

   // interlock countdown width, holds up to 2
   localparam int STALL_CNT_W = 2;

   // $zero never causes a hazard and always reads 0
   localparam logic [4:0] REG_RA_ZERO = 5'd0;

   typedef enum logic [3:0] {
      ALU_ADDU,
      ALU_SUBU,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_NOR,
      ALU_SLT,
      ALU_SLTU,
      ALU_SLL,
      ALU_SRL,
      ALU_SRA
   } alu_op_e;

   typedef enum logic [2:0] {
      LD_NONE,
      LD_LB,
      LD_LBU,
      LD_LH,
      LD_LHU,
      LD_LW,
      LD_LUI
   } load_fmt_e;

   typedef enum logic [1:0] {
      ST_NONE,
      ST_SB,
      ST_SH,
      ST_SW
   } store_fmt_e;

   // control word carried down the pipe
   typedef struct packed {
      logic       reg_we;
      alu_op_e    alu_op;
      logic       alu_src_imm;
      logic       sign_ext;
      logic       shift_by_reg;
      load_fmt_e  load_fmt;
      store_fmt_e store_fmt;
      logic       reserved;
   } ctrl_t;

   // no register write, no store
   localparam ctrl_t CTRL_BUBBLE = '{
      reg_we:       1'b0,
      alu_op:       ALU_ADDU,
      alu_src_imm:  1'b0,
      sign_ext:     1'b0,
      shift_by_reg: 1'b0,
      load_fmt:     LD_NONE,
      store_fmt:    ST_NONE,
      reserved:     1'b0
   };

endpackage

`default_nettype wire

// ==== hw/mips_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_decode
   import isa_pkg::*, core_pkg::*;
(
   input  wire instr_t instr,
   output ctrl_t       ctrl,
   output reg_idx_t    dest
);

   always_comb begin
      ctrl = CTRL_BUBBLE;
      // i-type writes rt, r-type overrides with rd
      dest = instr.rt;
      case (instr.op)
         OP_SPECIAL: begin
            dest        = instr.rd;
            ctrl.reg_we = 1'b1;
            case (instr.funct)
               FN_SLL:  ctrl.alu_op = ALU_SLL;
               FN_SRL:  ctrl.alu_op = ALU_SRL;
               FN_SRA:  ctrl.alu_op = ALU_SRA;
               // variable shifts take the amount from rs
               FN_SLLV: begin
                  ctrl.alu_op       = ALU_SLL;
                  ctrl.shift_by_reg = 1'b1;
               end
               FN_SRLV: begin
                  ctrl.alu_op       = ALU_SRL;
                  ctrl.shift_by_reg = 1'b1;
               end
               FN_SRAV: begin
                  ctrl.alu_op       = ALU_SRA;
                  ctrl.shift_by_reg = 1'b1;
               end
               FN_ADDU: ctrl.alu_op = ALU_ADDU;
               FN_SUBU: ctrl.alu_op = ALU_SUBU;
               FN_AND:  ctrl.alu_op = ALU_AND;
               FN_OR:   ctrl.alu_op = ALU_OR;
               FN_XOR:  ctrl.alu_op = ALU_XOR;
               FN_NOR:  ctrl.alu_op = ALU_NOR;
               FN_SLT:  ctrl.alu_op = ALU_SLT;
               FN_SLTU: ctrl.alu_op = ALU_SLTU;
               // a reserved word must reach wb without touching the register file
               default: begin
                  ctrl.reg_we   = 1'b0;
                  ctrl.reserved = 1'b1;
               end
            endcase
         end
         // arithmetic immediates sign extend, logical ones zero extend
         OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI: begin
            ctrl.reg_we      = 1'b1;
            ctrl.alu_src_imm = 1'b1;
            ctrl.sign_ext    = (instr.op == OP_ADDIU) || (instr.op == OP_SLTI) ||
                               (instr.op == OP_SLTIU);
            case (instr.op)
               OP_SLTI:  ctrl.alu_op = ALU_SLT;
               OP_SLTIU: ctrl.alu_op = ALU_SLTU;
               OP_ANDI:  ctrl.alu_op = ALU_AND;
               OP_ORI:   ctrl.alu_op = ALU_OR;
               OP_XORI:  ctrl.alu_op = ALU_XOR;
               default:  ctrl.alu_op = ALU_ADDU;
            endcase
         end
         // lui goes through the load formatter, rt is not read
         OP_LUI: begin
            ctrl.reg_we      = 1'b1;
            ctrl.alu_src_imm = 1'b1;
            ctrl.load_fmt    = LD_LUI;
         end
         OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW: begin
            ctrl.reg_we      = 1'b1;
            ctrl.alu_src_imm = 1'b1;
            ctrl.sign_ext    = 1'b1;
            case (instr.op)
               OP_LB:   ctrl.load_fmt = LD_LB;
               OP_LBU:  ctrl.load_fmt = LD_LBU;
               OP_LH:   ctrl.load_fmt = LD_LH;
               OP_LHU:  ctrl.load_fmt = LD_LHU;
               default: ctrl.load_fmt = LD_LW;
            endcase
         end
         OP_SB, OP_SH, OP_SW: begin
            ctrl.alu_src_imm = 1'b1;
            ctrl.sign_ext    = 1'b1;
            case (instr.op)
               OP_SB:   ctrl.store_fmt = ST_SB;
               OP_SH:   ctrl.store_fmt = ST_SH;
               default: ctrl.store_fmt = ST_SW;
            endcase
         end
         default: ctrl.reserved = 1'b1;
      endcase
   end

endmodule

`default_nettype wire

// ==== hw/mips_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_regfile
   import isa_pkg::*, core_pkg::*;
(
   input  wire           clk,
   input  wire           rst_b,
   input  wire reg_idx_t rs_idx,
   input  wire reg_idx_t rt_idx,
   input  wire reg_idx_t wr_idx,
   input  wire word_t    wr_data,
   input  wire           wr_en,
   output word_t         rs_data,
   output word_t         rt_data
);

   word_t regs [32];

   // wb value bypasses the array when it targets the same register
   function automatic word_t read_port(reg_idx_t idx, word_t stored);
      if (idx == REG_RA_ZERO)
         return '0;
      if (wr_en && (wr_idx == idx))
         return wr_data;
      return stored;
   endfunction

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         for (int i = 0; i < 32; i++)
            regs[i] <= '0;
      end else if (wr_en && (wr_idx != REG_RA_ZERO)) begin
         regs[wr_idx] <= wr_data;
      end
   end

   assign rs_data = read_port(rs_idx, regs[rs_idx]);
   assign rt_data = read_port(rt_idx, regs[rt_idx]);

endmodule

`default_nettype wire

// ==== hw/mips_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_alu
   import isa_pkg::*, core_pkg::*;
(
   input  wire alu_op_e    op,
   input  wire word_t      a,
   input  wire word_t      b,
   input  wire logic [4:0] shamt,
   output word_t           result
);

   always_comb begin
      case (op)
         ALU_ADDU: result = a + b;
         ALU_SUBU: result = a - b;
         ALU_AND:  result = a & b;
         ALU_OR:   result = a | b;
         ALU_XOR:  result = a ^ b;
         ALU_NOR:  result = ~(a | b);
         // signed and unsigned compare give 0 or 1
         ALU_SLT:  result = {31'b0, $signed(a) < $signed(b)};
         ALU_SLTU: result = {31'b0, a < b};
         // shifts move b (rt), the amount is the instruction field or a[4:0]
         ALU_SLL:  result = b << shamt;
         ALU_SRL:  result = b >> shamt;
         ALU_SRA:  result = $signed(b) >>> shamt;
         default:  result = a + b;
      endcase
   end

endmodule

`default_nettype wire

// ==== hw/hazard_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazard_unit
   import isa_pkg::*, core_pkg::*;
(
   input  wire           clk,
   input  wire           rst_b,
   input  wire reg_idx_t rs_idx,
   input  wire reg_idx_t rt_idx,
   input  wire           uses_rt,
   input  wire reg_idx_t ex_dest,
   input  wire reg_idx_t mem_dest,
   input  wire           ex_we,
   input  wire           mem_we,
   output logic          hold
);

   logic [STALL_CNT_W-1:0] cnt_q;
   logic [STALL_CNT_W-1:0] cnt_now;
   logic [STALL_CNT_W-1:0] hazard_amt;
   logic                   hit_ex;
   logic                   hit_mem;

   // does the id instruction read register dst
   function automatic logic reads_reg(reg_idx_t dst);
      logic rs_hit;
      logic rt_hit;
      rs_hit = (rs_idx != REG_RA_ZERO) && (rs_idx == dst);
      rt_hit = uses_rt && (rt_idx != REG_RA_ZERO) && (rt_idx == dst);
      return rs_hit || rt_hit;
   endfunction

   always_comb begin
      hit_ex  = ex_we && reads_reg(ex_dest);
      hit_mem = mem_we && reads_reg(mem_dest);
      // producer in ex is 2 cycles from wb, in mem 1
      if (hit_ex)
         hazard_amt = 2'd2;
      else if (hit_mem)
         hazard_amt = 2'd1;
      else
         hazard_amt = '0;
      // a running countdown wins over a fresh compare
      cnt_now = (cnt_q != '0) ? cnt_q : hazard_amt;
      hold    = (cnt_now != '0);
   end

   // register keeps what is left after the current held cycle
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b)
         cnt_q <= '0;
      else if (hold)
         cnt_q <= cnt_now - 1'b1;
      else
         cnt_q <= '0;
   end

   cnt_max_a: assert property (@(posedge clk) disable iff (!rst_b) cnt_now <= 2'd2);

endmodule

`default_nettype wire

// ==== hw/mem_align.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_align
   import isa_pkg::*, core_pkg::*;
(
   input  wire logic [1:0]  addr_lo,
   input  wire load_fmt_e   load_fmt,
   input  wire store_fmt_e  store_fmt,
   input  wire word_t       rt_data,
   input  wire word_t       rd_mem,
   input  wire logic [15:0] imm,
   output word_t            load_data,
   output word_t            wr_data,
   output logic [3:0]       byte_en
);

   word_t shifted;

   // addressed byte moved down to lane 0
   assign shifted = rd_mem >> {addr_lo, 3'b000};

   always_comb begin
      case (load_fmt)
         LD_LB:   load_data = {{24{shifted[7]}}, shifted[7:0]};
         LD_LBU:  load_data = {24'b0, shifted[7:0]};
         LD_LH:   load_data = {{16{shifted[15]}}, shifted[15:0]};
         LD_LHU:  load_data = {16'b0, shifted[15:0]};
         LD_LW:   load_data = rd_mem;
         // lui needs no memory, imm lands in the upper half
         LD_LUI:  load_data = {imm, 16'b0};
         default: load_data = '0;
      endcase
   end

   always_comb begin
      case (store_fmt)
         ST_SB: begin
            wr_data = {24'b0, rt_data[7:0]} << {addr_lo, 3'b000};
            byte_en = 4'b0001 << addr_lo;
         end
         ST_SH: begin
            wr_data = {16'b0, rt_data[15:0]} << {addr_lo, 3'b000};
            byte_en = 4'b0011 << addr_lo;
         end
         ST_SW: begin
            wr_data = rt_data;
            byte_en = 4'b1111;
         end
         default: begin
            wr_data = rt_data;
            byte_en = 4'b0000;
         end
      endcase
      // halfword must not straddle lanes 1 and 2
      assert (store_fmt != ST_SH || !addr_lo[0]);
   end

endmodule

`default_nettype wire

// ==== hw/mips_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_core
   import isa_pkg::*, core_pkg::*;
(
   input  wire          clk,
   input  wire          rst_b,
   output logic [29:0]  inst_addr,
   input  wire word_t   inst,
   output logic [29:0]  mem_addr,
   output word_t        mem_data_in,
   input  wire word_t   mem_data_out,
   output logic [3:0]   mem_write_en,
   output logic         halted
);

   logic [31:0] pc;
   instr_u      ifid;
   logic        hold;

   // id stage
   ctrl_t    ctrl_id;
   reg_idx_t dest_id;
   word_t    rs_data;
   word_t    rt_data;
   word_t    imm_id;
   logic     uses_rt_id;

   // id/ex
   ctrl_t      ctrl_ex;
   word_t      rs_ex;
   word_t      rt_ex;
   word_t      imm_ex;
   logic [4:0] shamt_ex;
   reg_idx_t   dest_ex;
   word_t      alu_b;
   logic [4:0] alu_shamt;
   word_t      alu_res;

   // ex/mem
   ctrl_t       ctrl_mem;
   word_t       alu_mem;
   word_t       rt_mem;
   logic [15:0] imm16_mem;
   reg_idx_t    dest_mem;
   word_t       load_data;
   logic [3:0]  byte_en;

   // mem/wb
   ctrl_t    ctrl_wb;
   word_t    load_wb;
   word_t    alu_wb;
   reg_idx_t dest_wb;
   word_t    wb_data;

   assign inst_addr = pc[31:2];

   // pc and if/id freeze on a hazard, pc also stops once halted
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         pc     <= TEXT_START;
         ifid   <= '0;
         halted <= 1'b0;
      end else begin
         if (!hold && !halted)
            pc <= pc + 32'd4;
         if (!hold)
            ifid <= inst;
         halted <= halted | ctrl_wb.reserved;
      end
   end

   mips_decode u_decode (
      .instr (ifid.r),
      .ctrl  (ctrl_id),
      .dest  (dest_id)
   );

   mips_regfile u_regfile (
      .clk     (clk),
      .rst_b   (rst_b),
      .rs_idx  (ifid.r.rs),
      .rt_idx  (ifid.r.rt),
      .wr_idx  (dest_wb),
      .wr_data (wb_data),
      .wr_en   (ctrl_wb.reg_we),
      .rs_data (rs_data),
      .rt_data (rt_data)
   );

   assign imm_id = ctrl_id.sign_ext ? {{16{ifid.i.imm[15]}}, ifid.i.imm}
                                    : {16'b0, ifid.i.imm};

   // rt is a source for r-type and for store data
   assign uses_rt_id = !ctrl_id.alu_src_imm || (ctrl_id.store_fmt != ST_NONE);

   hazard_unit u_hazard (
      .clk      (clk),
      .rst_b    (rst_b),
      .rs_idx   (ifid.r.rs),
      .rt_idx   (ifid.r.rt),
      .uses_rt  (uses_rt_id),
      .ex_dest  (dest_ex),
      .mem_dest (dest_mem),
      .ex_we    (ctrl_ex.reg_we),
      .mem_we   (ctrl_mem.reg_we),
      .hold     (hold)
   );

   // control flops, a held id stage sends a bubble into ex
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         ctrl_ex  <= CTRL_BUBBLE;
         ctrl_mem <= CTRL_BUBBLE;
         ctrl_wb  <= CTRL_BUBBLE;
      end else begin
         ctrl_ex  <= hold ? CTRL_BUBBLE : ctrl_id;
         ctrl_mem <= ctrl_ex;
         ctrl_wb  <= ctrl_mem;
      end
   end

   // data side of the stage registers
   always_ff @(posedge clk) begin
      rs_ex     <= rs_data;
      rt_ex     <= rt_data;
      imm_ex    <= imm_id;
      shamt_ex  <= ifid.r.shamt;
      dest_ex   <= dest_id;
      alu_mem   <= alu_res;
      rt_mem    <= rt_ex;
      imm16_mem <= imm_ex[15:0];
      dest_mem  <= dest_ex;
      load_wb   <= load_data;
      alu_wb    <= alu_mem;
      dest_wb   <= dest_mem;
   end

   assign alu_b     = ctrl_ex.alu_src_imm ? imm_ex : rt_ex;
   assign alu_shamt = ctrl_ex.shift_by_reg ? rs_ex[4:0] : shamt_ex;

   mips_alu u_alu (
      .op     (ctrl_ex.alu_op),
      .a      (rs_ex),
      .b      (alu_b),
      .shamt  (alu_shamt),
      .result (alu_res)
   );

   mem_align u_mem_align (
      .addr_lo   (alu_mem[1:0]),
      .load_fmt  (ctrl_mem.load_fmt),
      .store_fmt (ctrl_mem.store_fmt),
      .rt_data   (rt_mem),
      .rd_mem    (mem_data_out),
      .imm       (imm16_mem),
      .load_data (load_data),
      .wr_data   (mem_data_in),
      .byte_en   (byte_en)
   );

   assign mem_addr = alu_mem[31:2];

   // anything younger than a reserved word at wb must not store
   assign mem_write_en = (halted || ctrl_wb.reserved) ? 4'b0000 : byte_en;

   assign wb_data = (ctrl_wb.load_fmt != LD_NONE) ? load_wb : alu_wb;

   // once a producer reaches wb the bubbles ahead of it leave no hazard
   hold_max_a: assert property (@(posedge clk) disable iff (!rst_b)
      hold ##1 hold |=> !hold);

endmodule

`default_nettype wire

// ==== tb/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
   output logic clk,
   output logic rst_b
);

   // 40 ns period, first rising edge at 20 ns
   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // reset spans three rising edges and is released on a falling edge
   initial begin
      rst_b = 1'b0;
      repeat (3) @(posedge clk);
      @(negedge clk);
      rst_b = 1'b1;
   end

endmodule

`default_nettype wire

// ==== tb/tb_mips_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mips_core
   import isa_pkg::*, core_pkg::*;
();

   // opcode 0x3f is not implemented, the core halts on it
   localparam word_t RESERVED_WORD = 32'hfc00_0000;

   // one expected store as seen on the data port
   typedef struct packed {
      logic [2:0]  test;
      logic [29:0] addr;
      logic [3:0]  be;
      word_t       data;
   } store_t;

   logic        clk;
   logic        rst_b;
   logic [29:0] inst_addr;
   word_t       inst;
   logic [29:0] mem_addr;
   word_t       mem_data_in;
   word_t       mem_data_out;
   logic [3:0]  mem_write_en;
   logic        halted;
   logic [29:0] fetch_idx;

   word_t  imem [512];
   word_t  dmem [256];
   word_t  model_mem [256];
   word_t  model_regs [32];
   store_t exp_q [$];
   word_t  rng = 32'he0a3_b306;
   int     prog_len;
   int     next_slot = 512;
   int     last_slot;
   int     cur_test;
   int     stores_total;
   int     stores_seen;
   int     test_end [7];
   int     test_checks [7];
   int     test_errs [7];

   string  test_names [7] = '{"", "reset", "alu operations", "interlock",
                              "byte stores", "loads", "halt"};
   funct_e  r_fns [14] = '{FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV, FN_ADDU,
                           FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLT, FN_SLTU};
   opcode_e i_ops [6] = '{OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI};

   tb_clock u_clock (
      .clk   (clk),
      .rst_b (rst_b)
   );

   mips_core UUT (
      .clk          (clk),
      .rst_b        (rst_b),
      .inst_addr    (inst_addr),
      .inst         (inst),
      .mem_addr     (mem_addr),
      .mem_data_in  (mem_data_in),
      .mem_data_out (mem_data_out),
      .mem_write_en (mem_write_en),
      .halted       (halted)
   );

   // instruction port answers in the same cycle
   assign fetch_idx    = inst_addr - TEXT_START[31:2];
   assign inst         = (fetch_idx < 30'd512) ? imem[fetch_idx[8:0]] : RESERVED_WORD;
   assign mem_data_out = dmem[mem_addr[7:0]];

   // byte-enabled data writes at the end of the store's mem cycle
   always @(posedge clk) begin
      for (int k = 0; k < 4; k++)
         if (mem_write_en[k])
            dmem[mem_addr[7:0]][8*k +: 8] = mem_data_in[8*k +: 8];
   end

   function automatic word_t xorshift(word_t x);
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      return x ^ (x << 5);
   endfunction

   function word_t rand_word();
      rng = xorshift(rng);
      return rng;
   endfunction

   function automatic word_t sext16(logic [15:0] v);
      return {{16{v[15]}}, v};
   endfunction

   function automatic word_t sext8(logic [7:0] v);
      return {{24{v[7]}}, v};
   endfunction

   // flipping the sign bits turns a signed compare into an unsigned one
   function automatic logic lt_signed(word_t a, word_t b);
      return (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);
   endfunction

   // expected r-type result, s is rs and t is rt
   function automatic word_t model_r(funct_e fn, word_t s, word_t t, logic [4:0] sa);
      logic [4:0] amt;
      amt = (fn == FN_SLLV || fn == FN_SRLV || fn == FN_SRAV) ? s[4:0] : sa;
      case (fn)
         FN_SLL, FN_SLLV: return t << amt;
         FN_SRL, FN_SRLV: return t >> amt;
         // negative values shift in ones, done as an inverted logical shift
         FN_SRA, FN_SRAV: return t[31] ? ~(~t >> amt) : (t >> amt);
         FN_ADDU: return s + t;
         FN_SUBU: return s + ~t + 32'd1;
         FN_AND:  return s & t;
         FN_OR:   return s | t;
         FN_XOR:  return s ^ t;
         FN_NOR:  return ~s & ~t;
         FN_SLT:  return {31'b0, lt_signed(s, t)};
         FN_SLTU: return {31'b0, s < t};
         default: return '0;
      endcase
   endfunction

   task automatic put(word_t w);
      imem[prog_len] = w;
      prog_len++;
   endtask

   task automatic do_r(funct_e fn, reg_idx_t rd, reg_idx_t rs, reg_idx_t rt, logic [4:0] sa);
      put({OP_SPECIAL, rs, rt, rd, sa, fn});
      if (rd != 5'd0)
         model_regs[rd] = model_r(fn, model_regs[rs], model_regs[rt], sa);
   endtask

   // i-type instruction, the model follows it in program order
   task automatic do_i(opcode_e op, reg_idx_t rt, reg_idx_t rs, logic [15:0] imm);
      word_t  ea;
      word_t  mw;
      word_t  v;
      int     off;
      store_t st;
      put({op, rs, rt, imm});
      ea  = model_regs[rs] + sext16(imm);
      mw  = model_mem[ea[9:2]];
      off = ea[1:0];
      v   = '0;
      st  = '0;
      case (op)
         OP_ADDIU: v = ea;
         OP_SLTI:  v = {31'b0, lt_signed(model_regs[rs], sext16(imm))};
         OP_SLTIU: v = {31'b0, model_regs[rs] < sext16(imm)};
         OP_ANDI:  v = model_regs[rs] & {16'h0, imm};
         OP_ORI:   v = model_regs[rs] | {16'h0, imm};
         OP_XORI:  v = model_regs[rs] ^ {16'h0, imm};
         OP_LUI:   v = {imm, 16'h0};
         OP_LB:    v = sext8(mw[8*off +: 8]);
         OP_LBU:   v = {24'h0, mw[8*off +: 8]};
         OP_LH:    v = sext16(mw[8*off +: 16]);
         OP_LHU:   v = {16'h0, mw[8*off +: 16]};
         OP_LW:    v = mw;
         OP_SB: begin
            st.be[off]          = 1'b1;
            st.data[8*off +: 8] = model_regs[rt][7:0];
         end
         OP_SH: begin
            st.be[off +: 2]      = 2'b11;
            st.data[8*off +: 16] = model_regs[rt][15:0];
         end
         OP_SW: begin
            st.be   = 4'hf;
            st.data = model_regs[rt];
         end
         default: v = '0;
      endcase
      if (st.be != 4'h0) begin
         st.addr = ea[31:2];
         st.test = 3'(cur_test);
         exp_q.push_back(st);
         stores_total++;
         for (int k = 0; k < 4; k++)
            if (st.be[k])
               model_mem[ea[9:2]][8*k +: 8] = st.data[8*k +: 8];
      end else if (rt != 5'd0) begin
         model_regs[rt] = v;
      end
   endtask

   // lui then ori, the ori depends on the lui right before it
   task automatic load_const(reg_idx_t rt, word_t v);
      do_i(OP_LUI, rt, 5'd0, v[31:16]);
      do_i(OP_ORI, rt, rt, v[15:0]);
   endtask

   task automatic store_word(reg_idx_t rt);
      last_slot = next_slot;
      do_i(OP_SW, rt, 5'd0, 16'(next_slot));
      next_slot += 4;
   endtask

   task automatic report_mismatch(int t, string what);
      $display("Fail at %0t ns: %s", $time, what);
      test_errs[t]++;
   endtask

   task automatic report_problem(int t, string what);
      $display("%s", what);
      test_errs[t]++;
   endtask

   task automatic show_test(int t);
      $display("test %0d %s: %0d checks, %0d errors", t, test_names[t], test_checks[t],
               test_errs[t]);
   endtask

   // every store pulse is matched against the oldest expected store
   always @(negedge clk) begin
      store_t head;
      word_t  mask;
      if (mem_write_en != 4'b0000) begin
         if (exp_q.size() == 0) begin
            report_problem(6, $sformatf("store to word %h with enables %b was not expected",
                                        mem_addr, mem_write_en));
         end else begin
            head = exp_q.pop_front();
            stores_seen++;
            test_checks[head.test]++;
            for (int k = 0; k < 4; k++)
               mask[8*k +: 8] = {8{head.be[k]}};
            store_match_a: assert (mem_addr == head.addr && mem_write_en == head.be &&
                                   (mem_data_in & mask) == (head.data & mask))
               else report_mismatch(head.test, $sformatf(
                  "store %0d word %h be %b data %h, expected word %h be %b data %h",
                  stores_seen, mem_addr, mem_write_en, mem_data_in, head.addr, head.be,
                  head.data));
            if (stores_seen == test_end[head.test])
               show_test(head.test);
         end
      end
   end

   initial begin
      word_t w;
      int    base;
      int    limit;
      int    total_chk;
      int    total_err;
      for (int i = 0; i < 512; i++)
         imem[i] = RESERVED_WORD;
      // tb memory and model share one random image
      for (int i = 0; i < 256; i++) begin
         dmem[i]      = rand_word();
         model_mem[i] = dmem[i];
      end

      cur_test = 2;
      foreach (r_fns[f]) begin
         load_const(5'd8, rand_word());
         load_const(5'd9, rand_word());
         w = rand_word();
         do_r(r_fns[f], 5'd10, 5'd8, 5'd9, w[4:0]);
         store_word(5'd10);
      end
      // opposite signs so slt and sltu disagree
      load_const(5'd8, rand_word() | 32'h8000_0000);
      load_const(5'd9, rand_word() & 32'h7fff_ffff);
      do_r(FN_SLT, 5'd10, 5'd8, 5'd9, 5'd0);
      store_word(5'd10);
      do_r(FN_SLTU, 5'd10, 5'd8, 5'd9, 5'd0);
      store_word(5'd10);
      do_r(FN_SLT, 5'd10, 5'd9, 5'd8, 5'd0);
      store_word(5'd10);
      do_r(FN_SLTU, 5'd10, 5'd9, 5'd8, 5'd0);
      store_word(5'd10);
      foreach (i_ops[k]) begin
         load_const(5'd8, rand_word());
         w = rand_word();
         do_i(i_ops[k], 5'd10, 5'd8, w[15:0]);
         store_word(5'd10);
      end
      test_end[2] = stores_total;

      // dependency chain with no filler, then a load-use pair
      cur_test = 3;
      w = rand_word();
      do_i(OP_ADDIU, 5'd11, 5'd0, w[15:0]);
      do_r(FN_ADDU, 5'd12, 5'd11, 5'd11, 5'd0);
      do_r(FN_XOR, 5'd13, 5'd12, 5'd11, 5'd0);
      do_r(FN_SRAV, 5'd14, 5'd13, 5'd12, 5'd0);
      store_word(5'd14);
      do_i(OP_LW, 5'd15, 5'd0, 16'(last_slot));
      do_r(FN_SUBU, 5'd16, 5'd15, 5'd12, 5'd0);
      store_word(5'd16);
      // one nop between, producer sits in mem at decode
      do_i(OP_ADDIU, 5'd17, 5'd0, w[31:16]);
      do_r(FN_SLL, 5'd0, 5'd0, 5'd0, 5'd0);
      do_r(FN_NOR, 5'd18, 5'd17, 5'd16, 5'd0);
      store_word(5'd18);
      test_end[3] = stores_total;

      // sb at every lane, sh at both halves
      cur_test = 4;
      load_const(5'd20, rand_word());
      base = next_slot;
      next_slot += 8;
      for (int k = 0; k < 4; k++)
         do_i(OP_SB, 5'd20, 5'd0, 16'(base + k));
      for (int k = 0; k < 4; k += 2)
         do_i(OP_SH, 5'd20, 5'd0, 16'(base + 4 + k));
      test_end[4] = stores_total;

      // loads from the preloaded low words, each stored straight back
      cur_test = 5;
      for (int k = 0; k < 4; k++) begin
         do_i(OP_LB, 5'd21, 5'd0, 16'(4 * (3 + k) + k));
         store_word(5'd21);
         do_i(OP_LBU, 5'd21, 5'd0, 16'(4 * (3 + k) + k));
         store_word(5'd21);
      end
      for (int k = 0; k < 4; k += 2) begin
         do_i(OP_LH, 5'd21, 5'd0, 16'(36 + k));
         store_word(5'd21);
         do_i(OP_LHU, 5'd21, 5'd0, 16'(36 + k));
         store_word(5'd21);
      end
      do_i(OP_LW, 5'd21, 5'd0, 16'd40);
      store_word(5'd21);
      w = rand_word();
      do_i(OP_LUI, 5'd22, 5'd0, w[15:0]);
      store_word(5'd22);
      test_end[5] = stores_total;

      limit = prog_len * 40 + 100;
      fork
         begin
            repeat (limit) @(posedge clk);
            $display("watchdog: run did not finish within %0d cycles", limit);
            $display("Verification failed");
            $finish;
         end
      join_none

      // outputs quiet through reset and on the first cycle after it
      repeat (3) begin
         @(posedge clk);
         test_checks[1]++;
         reset_quiet_a: assert (mem_write_en == 4'b0000 && !halted)
            else report_mismatch(1, $sformatf("in reset: mem_write_en %b halted %b",
                                              mem_write_en, halted));
      end
      wait (rst_b === 1'b1);
      @(negedge clk);
      test_checks[1]++;
      first_cycle_a: assert (mem_write_en == 4'b0000 && !halted)
         else report_mismatch(1, $sformatf("after reset: mem_write_en %b halted %b",
                                           mem_write_en, halted));
      show_test(1);

      // tests 2 to 5 report from the store checker as their last store passes
      wait (halted === 1'b1);
      @(negedge clk);
      test_checks[6]++;
      queue_empty_a: assert (exp_q.size() == 0)
         else report_problem(6, $sformatf("core halted with %0d expected stores never seen",
                                          exp_q.size()));
      repeat (20) begin
         @(negedge clk);
         test_checks[6]++;
         halt_quiet_a: assert (halted && mem_write_en == 4'b0000)
            else report_mismatch(6, $sformatf("after halt: halted %b mem_write_en %b",
                                              halted, mem_write_en));
      end
      show_test(6);

      total_chk = 0;
      total_err = 0;
      for (int t = 1; t < 7; t++) begin
         total_chk += test_checks[t];
         total_err += test_errs[t];
      end
      $display("6 tests, %0d checks, %0d errors", total_chk, total_err);
      if (total_err == 0)
         $display("Verification passed");
      else
         $display("Verification failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== filelist.f ====
hw/isa_pkg.sv
hw/core_pkg.sv
hw/mips_decode.sv
hw/mips_regfile.sv
hw/mips_alu.sv
hw/hazard_unit.sv
hw/mem_align.sv
hw/mips_core.sv
tb/tb_clock.sv
tb/tb_mips_core.sv

// ==== Makefile ====
SIM = obj_dir/Vtb_mips_core

all: run

$(SIM): filelist.f $(shell cat filelist.f)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_mips_core -f filelist.f

run: $(SIM)
	$(SIM) | tee sim.log
	grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
